/* filelist.f */
+incdir+hw
hw/eth_rx_pkg.sv
hw/eth_frame_parser.sv
hw/eth_crc32_check.sv
hw/eth_rx_filter.sv
hw/eth_rx_top.sv
test/eth_rx_assert.sv
test/eth_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the Ethernet receive testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module eth_rx_tb -f filelist.f

./obj_dir/Veth_rx_tb 2>&1 | tee "${LOG}"

if grep -q "Test FAILED" "${LOG}"; then
    echo "Simulation reported a failure, see ${LOG}."
    exit 1
fi

echo "Simulation finished without failure."
exit 0

/* test/eth_rx_tb.sv */
`default_nettype none

module eth_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 47;

    localparam int GOOD        = 0;
    localparam int BAD_PAYLOAD = 1;
    localparam int BAD_FCS     = 2;
    localparam int BAD_PRE     = 3;
    localparam int NO_SFD      = 4;
    localparam int CUT_HDR     = 5;

    localparam eth_rx_pkg::mac_addr_t STATION = 48'h02_1A_2B_3C_4D_5E;
    localparam eth_rx_pkg::mac_addr_t FOREIGN = 48'h02_99_88_77_66_55;
    localparam eth_rx_pkg::mac_addr_t BCAST   = 48'hFFFF_FFFF_FFFF;

    logic                      clk;
    logic                      rst;
    eth_rx_pkg::byte_t         rx_d;
    logic                      rx_dv;
    logic                      promisc;
    eth_rx_pkg::rx_beat_t      payload;
    logic                      payload_valid;
    eth_rx_pkg::frame_status_t status;
    logic                      status_stb;
    eth_rx_pkg::frame_cnt_t    good_frames;
    eth_rx_pkg::frame_cnt_t    bad_frames;

    // Expected outputs, built from the bytes sent.
    eth_rx_pkg::rx_beat_t      exp_payload[$];
    eth_rx_pkg::frame_status_t exp_status[$];
    logic                      exp_full[$];
    eth_rx_pkg::rx_beat_t      exp_beat;
    eth_rx_pkg::frame_status_t exp_st;
    logic                      full_cmp;
    int                        exp_good;
    int                        exp_bad;

    eth_rx_top u_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .rx_d_i         (rx_d),
        .rx_dv_i        (rx_dv),
        .station_mac_i  (STATION),
        .promisc_i      (promisc),
        .payload_o      (payload),
        .payload_valid_o(payload_valid),
        .status_o       (status),
        .status_stb_o   (status_stb),
        .good_frames_o  (good_frames),
        .bad_frames_o   (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    // Bit-serial FCS, least significant bit of each byte first.
    function automatic logic [31:0] fcs_of(input eth_rx_pkg::byte_t data[$]);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[i][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    // ----------------------------------------
    // Frame generator
    // ----------------------------------------

    task automatic send_frame(input eth_rx_pkg::mac_addr_t dest, input int kind,
                              input logic promisc_on);
        eth_rx_pkg::byte_t      bytes[$];
        eth_rx_pkg::byte_t      line[$];
        eth_rx_pkg::mac_addr_t  src;
        eth_rx_pkg::ethertype_t etype;
        logic [31:0]            fcs;
        logic                   addr_ok;
        int                     len;
        int                     gap;
        int                     idx;
        len     = $urandom_range(64, 1);
        gap     = $urandom_range(12, 4);
        src     = {16'($urandom), $urandom};
        etype   = 16'($urandom);
        addr_ok = promisc_on || dest == STATION || dest == BCAST;
        for (int i = 5; i >= 0; i--) begin
            bytes.push_back(dest[i*8 +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            bytes.push_back(src[i*8 +: 8]);
        end
        bytes.push_back(etype[15:8]);
        bytes.push_back(etype[7:0]);
        for (int i = 0; i < len; i++) begin
            bytes.push_back(8'($urandom));
        end
        fcs = fcs_of(bytes);
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(fcs[i*8 +: 8]);
        end
        if (kind == BAD_PAYLOAD) begin
            idx        = 14 + int'($urandom_range(len - 1, 0));
            bytes[idx] = bytes[idx] ^ 8'h01;
        end else if (kind == BAD_FCS) begin
            bytes[bytes.size() - 1] = bytes[bytes.size() - 1] ^ 8'h80;
        end else if (kind == CUT_HDR) begin
            idx = $urandom_range(13, 1);
            while (bytes.size() > idx) begin
                void'(bytes.pop_back());
            end
        end

        if (kind == CUT_HDR) begin
            exp_status.push_back('0);
            exp_full.push_back(1'b0);
            exp_bad++;
        end else if (kind != BAD_PRE && kind != NO_SFD) begin
            if (addr_ok) begin
                for (int i = 0; i < len; i++) begin
                    exp_payload.push_back('{data: bytes[14 + i], last: (i == len - 1)});
                end
            end
            exp_status.push_back('{crc_ok: (kind == GOOD), addr_ok: addr_ok, len_ok: 1'b1,
                                   payload_len: 11'(len), ethertype: etype});
            exp_full.push_back(1'b1);
            if (kind == GOOD && addr_ok) begin
                exp_good++;
            end else begin
                exp_bad++;
            end
        end

        for (int i = 0; i < 7; i++) begin
            line.push_back(8'h55);
        end
        line.push_back(8'hD5);
        if (kind == BAD_PRE) begin
            line[$urandom_range(6, 1)] = 8'h5D;
        end else if (kind == NO_SFD) begin
            line[7] = 8'h55;
        end
        foreach (bytes[i]) begin
            line.push_back(bytes[i]);
        end

        foreach (line[i]) begin
            @(posedge clk);
            rx_d    <= line[i];
            rx_dv   <= 1'b1;
            promisc <= promisc_on;
        end
        @(posedge clk);
        rx_dv <= 1'b0;
        rx_d  <= 8'h00;
        repeat (gap - 1) @(posedge clk);
    endtask

    // ----------------------------------------
    // Output checks
    // ----------------------------------------

    always @(negedge clk) begin
        if (!rst && payload_valid) begin
            assert (exp_payload.size() != 0)
                else stop_on_error("A payload byte came out while none was expected.");
            exp_beat = exp_payload.pop_front();
            assert (payload == exp_beat)
                else stop_on_error($sformatf("FAIL %0d ns: payload %h last %b, expected %h last %b",
                                             $time, payload.data, payload.last,
                                             exp_beat.data, exp_beat.last));
        end
        if (!rst && status_stb) begin
            assert (exp_status.size() != 0)
                else stop_on_error("A status strobe came while no frame was expected.");
            exp_st   = exp_status.pop_front();
            full_cmp = exp_full.pop_front();
            if (full_cmp) begin
                assert (status == exp_st)
                    else stop_on_error($sformatf("FAIL %0d ns: status %h, expected %h",
                                                 $time, status, exp_st));
            end else begin
                // A cut-off header only fixes the length verdict.
                assert (!status.len_ok && status.payload_len == '0)
                    else stop_on_error($sformatf("FAIL %0d ns: cut frame status %h, len_ok set",
                                                 $time, status));
            end
        end
    end

    initial begin
        #(NUM_FRAMES * 100 * 8);
        $display("Timeout: the run did not finish in the expected time.");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        void'($urandom(32'hc4f2_0907));
        rst      = 1'b1;
        rx_d     = 8'h00;
        rx_dv    = 1'b0;
        promisc  = 1'b0;
        exp_good = 0;
        exp_bad  = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        repeat (20) send_frame(STATION, GOOD, 1'b0);
        repeat (4) send_frame(STATION, BAD_PAYLOAD, 1'b0);
        repeat (4) send_frame(STATION, BAD_FCS, 1'b0);
        repeat (4) send_frame(FOREIGN, GOOD, 1'b0);
        repeat (3) send_frame(BCAST, GOOD, 1'b0);
        repeat (3) send_frame(FOREIGN, GOOD, 1'b1);
        repeat (2) send_frame(STATION, BAD_PRE, 1'b0);
        repeat (2) send_frame(STATION, NO_SFD, 1'b0);
        repeat (3) send_frame(STATION, CUT_HDR, 1'b0);
        repeat (2) send_frame(STATION, GOOD, 1'b0);

        while (exp_status.size() != 0 || exp_payload.size() != 0) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);

        if (good_frames == 16'(exp_good) && bad_frames == 16'(exp_bad)) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error($sformatf("FAIL %0d ns: counters good %0d bad %0d, expected %0d %0d",
                                    $time, good_frames, bad_frames, exp_good, exp_bad));
        end
    end

endmodule

`default_nettype wire

/* test/eth_rx_assert.sv */
`default_nettype none

module eth_rx_assert (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   rx_dv_i,
    input logic                   payload_valid_i,
    input logic                   status_stb_i,
    input eth_rx_pkg::frame_cnt_t good_frames_i,
    input eth_rx_pkg::frame_cnt_t bad_frames_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic frame_closed_q;

    // Set by a status strobe, cleared once the next frame starts on GMII.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            frame_closed_q <= 1'b0;
        end else if (status_stb_i) begin
            frame_closed_q <= 1'b1;
        end else if (rx_dv_i) begin
            frame_closed_q <= 1'b0;
        end
    end

    // ----------------------------------------
    // Reset and timing
    // ----------------------------------------

    reset_clear: assert property (@(posedge clk_i)
        rst_i |=> !payload_valid_i && !status_stb_i &&
                  good_frames_i == '0 && bad_frames_i == '0)
        else $error("Outputs or counters not clear after reset.");

    // Status comes 3 cycles after the data-valid flag first reads low.
    status_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        status_stb_i |-> !$past(rx_dv_i, 3) && $past(rx_dv_i, 4))
        else $error("Status strobe not 3 cycles after the end of the frame.");

    no_payload_after_status: assert property (@(posedge clk_i) disable iff (rst_i)
        frame_closed_q |-> !payload_valid_i)
        else $error("Payload byte after status before a new frame started.");

endmodule

bind eth_rx_top eth_rx_assert u_assert (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rx_dv_i        (rx_dv_i),
    .payload_valid_i(payload_valid_o),
    .status_stb_i   (status_stb_o),
    .good_frames_i  (good_frames_o),
    .bad_frames_i   (bad_frames_o)
);

`default_nettype wire

/* hw/eth_rx_top.sv */
`default_nettype none

module eth_rx_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  eth_rx_pkg::byte_t         rx_d_i,
    input  logic                      rx_dv_i,
    input  eth_rx_pkg::mac_addr_t     station_mac_i,
    input  logic                      promisc_i,
    output eth_rx_pkg::rx_beat_t      payload_o,
    output logic                      payload_valid_o,
    output eth_rx_pkg::frame_status_t status_o,
    output logic                      status_stb_o,
    output eth_rx_pkg::frame_cnt_t    good_frames_o,
    output eth_rx_pkg::frame_cnt_t    bad_frames_o
);

    eth_rx_pkg::rx_beat_t     rx_q;
    logic                     rx_valid_q;

    eth_rx_pkg::rx_beat_t     parser_payload;
    logic                     parser_payload_stb;
    eth_rx_pkg::eth_header_t  parser_hdr;
    logic                     parser_end_stb;
    logic                     parser_len_ok;
    eth_rx_pkg::payload_len_t parser_len;
    logic                     crc_done_stb;
    logic                     crc_ok;

    // ----------------------------------------
    // GMII input register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= rx_dv_i;
        end
    end

    // Frame end travels on the valid bit here.
    always_ff @(posedge clk_i) begin
        rx_q <= '{data: rx_d_i, last: 1'b0};
    end

    eth_frame_parser u_parser (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .rx_i           (rx_q),
        .rx_valid_i     (rx_valid_q),
        .payload_o      (parser_payload),
        .payload_stb_o  (parser_payload_stb),
        .hdr_o          (parser_hdr),
        .frame_end_stb_o(parser_end_stb),
        .len_ok_o       (parser_len_ok),
        .payload_len_o  (parser_len)
    );

    eth_crc32_check u_crc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rx_i          (rx_q),
        .rx_valid_i    (rx_valid_q),
        .crc_done_stb_o(crc_done_stb),
        .crc_ok_o      (crc_ok)
    );

    eth_rx_filter u_filter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .payload_i      (parser_payload),
        .payload_stb_i  (parser_payload_stb),
        .hdr_i          (parser_hdr),
        .frame_end_stb_i(parser_end_stb),
        .len_ok_i       (parser_len_ok),
        .payload_len_i  (parser_len),
        .crc_done_stb_i (crc_done_stb),
        .crc_ok_i       (crc_ok),
        .station_mac_i  (station_mac_i),
        .promisc_i      (promisc_i),
        .payload_o      (payload_o),
        .payload_valid_o(payload_valid_o),
        .status_o       (status_o),
        .status_stb_o   (status_stb_o),
        .good_frames_o  (good_frames_o),
        .bad_frames_o   (bad_frames_o)
    );

endmodule

`default_nettype wire

/* hw/eth_rx_filter.sv */
`default_nettype none

module eth_rx_filter (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  eth_rx_pkg::rx_beat_t      payload_i,
    input  logic                      payload_stb_i,
    input  eth_rx_pkg::eth_header_t   hdr_i,
    input  logic                      frame_end_stb_i,
    input  logic                      len_ok_i,
    input  eth_rx_pkg::payload_len_t  payload_len_i,
    input  logic                      crc_done_stb_i,
    input  logic                      crc_ok_i,
    input  eth_rx_pkg::mac_addr_t     station_mac_i,
    input  logic                      promisc_i,
    output eth_rx_pkg::rx_beat_t      payload_o,
    output logic                      payload_valid_o,
    output eth_rx_pkg::frame_status_t status_o,
    output logic                      status_stb_o,
    output eth_rx_pkg::frame_cnt_t    good_frames_o,
    output eth_rx_pkg::frame_cnt_t    bad_frames_o
);

    localparam eth_rx_pkg::mac_addr_t BCAST_MAC = 48'hFFFF_FFFF_FFFF;

    logic addr_ok;
    logic crc_ok;
    logic frame_good;

    assign addr_ok = promisc_i ||
                     (hdr_i.dest == station_mac_i) ||
                     (hdr_i.dest == BCAST_MAC);

    // Both end strobes arrive together.
    assign crc_ok     = crc_done_stb_i & crc_ok_i;
    assign frame_good = crc_ok & addr_ok & len_ok_i;

    // ----------------------------------------
    // Payload forwarding
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            payload_valid_o <= 1'b0;
        end else begin
            payload_valid_o <= payload_stb_i & addr_ok;
        end
    end

    always_ff @(posedge clk_i) begin
        if (payload_stb_i) begin
            payload_o <= payload_i;
        end
    end

    // ----------------------------------------
    // Status and statistics
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (frame_end_stb_i) begin
            status_o <= '{
                crc_ok:      crc_ok,
                addr_ok:     addr_ok,
                len_ok:      len_ok_i,
                payload_len: payload_len_i,
                ethertype:   hdr_i.ethertype
            };
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            status_stb_o  <= 1'b0;
            good_frames_o <= '0;
            bad_frames_o  <= '0;
        end else begin
            status_stb_o <= frame_end_stb_i;
            if (frame_end_stb_i) begin
                // Counters hold at full scale.
                if (frame_good) begin
                    if (good_frames_o != '1) begin
                        good_frames_o <= good_frames_o + 16'd1;
                    end
                end else if (bad_frames_o != '1) begin
                    bad_frames_o <= bad_frames_o + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/eth_crc32_check.sv */
`default_nettype none

`include "eth_rx_cfg.svh"

module eth_crc32_check (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  eth_rx_pkg::rx_beat_t rx_i,
    input  logic                 rx_valid_i,
    output logic                 crc_done_stb_o,
    output logic                 crc_ok_o
);

    // Reflected form of 04C11DB7.
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;

    logic [31:0] crc_q;
    logic        active_q;
    logic        pre_seen_q;
    logic        sfd_hit;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                             input eth_rx_pkg::byte_t data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    assign sfd_hit = !active_q && rx_valid_i && pre_seen_q && rx_i.data == `ETH_SFD_VAL;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q       <= 1'b0;
            pre_seen_q     <= 1'b0;
            crc_done_stb_o <= 1'b0;
            crc_ok_o       <= 1'b0;
        end else begin
            crc_done_stb_o <= 1'b0;
            pre_seen_q     <= rx_valid_i && rx_i.data == `ETH_PREAMBLE_VAL;
            if (sfd_hit) begin
                active_q <= 1'b1;
            end else if (active_q && !rx_valid_i) begin
                active_q       <= 1'b0;
                crc_done_stb_o <= 1'b1;
                crc_ok_o       <= (crc_q == `ETH_CRC_RESIDUE);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sfd_hit) begin
            crc_q <= '1;
        end else if (active_q && rx_valid_i) begin
            crc_q <= crc_byte(crc_q, rx_i.data);
        end
    end

endmodule

`default_nettype wire

/* hw/eth_frame_parser.sv */
`default_nettype none

`include "eth_rx_cfg.svh"

module eth_frame_parser (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_rx_pkg::rx_beat_t     rx_i,
    input  logic                     rx_valid_i,
    output eth_rx_pkg::rx_beat_t     payload_o,
    output logic                     payload_stb_o,
    output eth_rx_pkg::eth_header_t  hdr_o,
    output logic                     frame_end_stb_o,
    output logic                     len_ok_o,
    output eth_rx_pkg::payload_len_t payload_len_o
);

    localparam int HDR_BITS = `ETH_HEADER_BYTES * 8;

    eth_rx_pkg::parser_state_t state_q;

    logic       valid_d;
    logic       frame_start;
    logic [2:0] pre_cnt;
    logic [3:0] hdr_cnt;
    logic [2:0] hold_cnt;
    logic       hold_full;
    logic       out_stb_q;

    eth_rx_pkg::byte_t [`ETH_FCS_BYTES-1:0] hold_q;
    eth_rx_pkg::byte_t                      out_data_q;
    eth_rx_pkg::eth_header_t                hdr_q;
    eth_rx_pkg::payload_len_t               pay_cnt;

    assign frame_start = rx_valid_i & ~valid_d;
    assign hold_full   = (hold_cnt == 3'(`ETH_FCS_BYTES));

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= eth_rx_pkg::IDLE;
            valid_d   <= 1'b0;
            out_stb_q <= 1'b0;
            pre_cnt   <= '0;
            hdr_cnt   <= '0;
            hold_cnt  <= '0;
            pay_cnt   <= '0;
        end else begin
            valid_d   <= rx_valid_i;
            out_stb_q <= 1'b0;
            case (state_q)
                eth_rx_pkg::IDLE: begin
                    // Only a rising valid can open a frame.
                    if (frame_start && rx_i.data == `ETH_PREAMBLE_VAL) begin
                        state_q <= eth_rx_pkg::PREAMBLE;
                        pre_cnt <= 3'd1;
                    end
                end
                eth_rx_pkg::PREAMBLE: begin
                    if (!rx_valid_i) begin
                        state_q <= eth_rx_pkg::IDLE;
                    end else if (pre_cnt == 3'(`ETH_PREAMBLE_BYTES)) begin
                        if (rx_i.data == `ETH_SFD_VAL) begin
                            state_q <= eth_rx_pkg::HEADER;
                            hdr_cnt <= '0;
                            pay_cnt <= '0;
                        end else begin
                            state_q <= eth_rx_pkg::IDLE;
                        end
                    end else if (rx_i.data == `ETH_PREAMBLE_VAL) begin
                        pre_cnt <= pre_cnt + 3'd1;
                    end else begin
                        state_q <= eth_rx_pkg::IDLE;
                    end
                end
                eth_rx_pkg::HEADER: begin
                    if (!rx_valid_i) begin
                        state_q <= eth_rx_pkg::DRAIN;
                    end else begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_cnt == 4'(`ETH_HEADER_BYTES - 1)) begin
                            state_q  <= eth_rx_pkg::PAYLOAD;
                            hold_cnt <= '0;
                        end
                    end
                end
                eth_rx_pkg::PAYLOAD: begin
                    if (!rx_valid_i) begin
                        // Whatever sits in the hold line is the FCS.
                        state_q <= eth_rx_pkg::DRAIN;
                    end else if (hold_full) begin
                        out_stb_q <= 1'b1;
                        if (pay_cnt != '1) begin
                            pay_cnt <= pay_cnt + 11'd1;
                        end
                    end else begin
                        hold_cnt <= hold_cnt + 3'd1;
                    end
                end
                eth_rx_pkg::DRAIN: begin
                    state_q <= eth_rx_pkg::IDLE;
                end
                default: begin
                    state_q <= eth_rx_pkg::IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Header and hold line
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (state_q == eth_rx_pkg::HEADER && rx_valid_i) begin
            hdr_q <= {hdr_q[HDR_BITS-9:0], rx_i.data};
        end
        if (state_q == eth_rx_pkg::PAYLOAD && rx_valid_i) begin
            hold_q     <= {hold_q[`ETH_FCS_BYTES-2:0], rx_i.data};
            out_data_q <= hold_q[`ETH_FCS_BYTES-1];
        end
    end

    // A release followed by a low valid was the final payload byte.
    assign payload_o.data = out_data_q;
    assign payload_o.last = out_stb_q & ~rx_valid_i;
    assign payload_stb_o  = out_stb_q;

    assign hdr_o           = hdr_q;
    assign frame_end_stb_o = (state_q == eth_rx_pkg::DRAIN);
    assign payload_len_o   = pay_cnt;
    assign len_ok_o        = (pay_cnt >= 11'(`ETH_MIN_PAYLOAD)) &&
                             (pay_cnt <= 11'(`ETH_MAX_PAYLOAD));

endmodule

`default_nettype wire

/* hw/eth_rx_pkg.sv */
`default_nettype none

package eth_rx_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [10:0] payload_len_t;
    typedef logic [15:0] frame_cnt_t;

    // ----------------------------------------
    // Frame records
    // ----------------------------------------

    // First byte on the wire sits in the top bits.
    typedef struct packed {
        mac_addr_t  dest;
        mac_addr_t  src;
        ethertype_t ethertype;
    } eth_header_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } rx_beat_t;

    typedef struct packed {
        logic         crc_ok;
        logic         addr_ok;
        logic         len_ok;
        payload_len_t payload_len;
        ethertype_t   ethertype;
    } frame_status_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        DRAIN
    } parser_state_t;

endpackage

`default_nettype wire

/* hw/eth_rx_cfg.svh */
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// ----------------------------------------
// Framing
// ----------------------------------------

`define ETH_PREAMBLE_BYTES 7
`define ETH_PREAMBLE_VAL   8'h55
`define ETH_SFD_VAL        8'hD5
`define ETH_HEADER_BYTES   14
`define ETH_FCS_BYTES      4

// ----------------------------------------
// Length limits and FCS
// ----------------------------------------

`define ETH_MIN_PAYLOAD 1
`define ETH_MAX_PAYLOAD 1500

// Register value after a good frame and its FCS, no final inversion.
`define ETH_CRC_RESIDUE 32'hDEBB20E3

`endif
